//--- common/hps_video_pkg.sv
package hps_video_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	typedef logic [15:0] io_word_t;       // Host data word
	typedef logic [7:0]  cmd_code_t;
	typedef logic [11:0] timing_field_t;  // Timing field or line number
	typedef logic [13:0] timing_sum_t;    // Room for a sum of four fields
	typedef logic [7:0]  led_bank_t;
	typedef logic [15:0] sync_cnt_t;      // Cycle counts inside a sync period

	//////////////////////////////////////////////////
	// Host commands
	//////////////////////////////////////////////////

	localparam cmd_code_t CMD_CFG          = 8'h01;
	localparam cmd_code_t CMD_VIDEO_TIMING = 8'h20;
	localparam cmd_code_t CMD_LED          = 8'h25;
	localparam cmd_code_t CMD_VS_LINE      = 8'h38;

	localparam int TIMING_WORDS  = 8;
	localparam int WORD_CNT_W    = $clog2(TIMING_WORDS) + 1;  // Holds 0..TIMING_WORDS
	localparam int CFG_CSYNC_BIT = 3;                         // Composite sync enable

	//////////////////////////////////////////////////
	// Timing defaults for 1920x1080 at 60 Hz
	//////////////////////////////////////////////////

	localparam timing_field_t DEF_WIDTH  = 12'd1920;
	localparam timing_field_t DEF_HFP    = 12'd88;
	localparam timing_field_t DEF_HS     = 12'd48;
	localparam timing_field_t DEF_HBP    = 12'd148;
	localparam timing_field_t DEF_HEIGHT = 12'd1080;
	localparam timing_field_t DEF_VFP    = 12'd4;
	localparam timing_field_t DEF_VS     = 12'd5;
	localparam timing_field_t DEF_VBP    = 12'd36;

	// Command decoder
	typedef enum logic {
		DEC_IDLE = 1'b0,  // Waiting for a command word
		DEC_DATA = 1'b1   // Data words for the held command
	} dec_state_t;

endpackage

//--- logic/uio_cmd_decoder.sv
`timescale 1ns/1ps

module uio_cmd_decoder (
	input  logic                          i_clk_sys,
	input  logic                          i_resetd,
	input  logic                          i_uio_sel,
	input  logic                          i_io_strobe,
	input  hps_video_pkg::io_word_t       i_io_din,
	input  logic [2:0]                    i_led_status,
	output hps_video_pkg::timing_field_t  o_width,
	output hps_video_pkg::timing_field_t  o_hfp,
	output hps_video_pkg::timing_field_t  o_hs_len,
	output hps_video_pkg::timing_field_t  o_hbp,
	output hps_video_pkg::timing_field_t  o_height,
	output hps_video_pkg::timing_field_t  o_vfp,
	output hps_video_pkg::timing_field_t  o_vs_len,
	output hps_video_pkg::timing_field_t  o_vbp,
	output logic                          o_csync_en,
	output hps_video_pkg::timing_field_t  o_vs_line,
	output hps_video_pkg::led_bank_t      o_led
);
	import hps_video_pkg::*;

	dec_state_t             state;
	cmd_code_t              cmd;
	logic [WORD_CNT_W-1:0]  word_cnt;   // Data words seen for command 0x20

	io_word_t       cfg;
	timing_field_t  fields [TIMING_WORDS];  // Width, HFP, HS, HBP, height, VFP, VS, VBP
	timing_field_t  vs_line;
	led_bank_t      led_mask;
	led_bank_t      led_state;
	led_bank_t      led_default;

	//////////////////////////////////////////////////
	// Command machine
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			state     <= DEC_IDLE;
			cmd       <= '0;
			word_cnt  <= '0;
			cfg       <= '0;
			vs_line   <= '0;
			led_mask  <= '0;
			led_state <= '0;
			fields[0] <= DEF_WIDTH;
			fields[1] <= DEF_HFP;
			fields[2] <= DEF_HS;
			fields[3] <= DEF_HBP;
			fields[4] <= DEF_HEIGHT;
			fields[5] <= DEF_VFP;
			fields[6] <= DEF_VS;
			fields[7] <= DEF_VBP;
		end else if (!i_uio_sel) begin
			state <= DEC_IDLE;  // Transaction closed
		end else if (i_io_strobe) begin
			case (state)
				DEC_IDLE: begin
					cmd      <= i_io_din[7:0];
					word_cnt <= '0;
					state    <= DEC_DATA;
				end
				DEC_DATA: begin
					case (cmd)
						CMD_CFG: begin
							cfg <= i_io_din;
						end
						CMD_VIDEO_TIMING: begin
							// Extra words past the eighth fall through
							if (word_cnt < TIMING_WORDS) begin
								fields[word_cnt[WORD_CNT_W-2:0]] <= i_io_din[11:0];
								word_cnt <= word_cnt + 1'b1;
							end
						end
						CMD_LED: begin
							led_mask  <= i_io_din[15:8];
							led_state <= i_io_din[7:0];
						end
						CMD_VS_LINE: begin
							vs_line <= i_io_din[11:0];
						end
						default: begin
							// Unknown command drops its data
						end
					endcase
				end
				default: begin
					state <= DEC_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	assign o_width    = fields[0];
	assign o_hfp      = fields[1];
	assign o_hs_len   = fields[2];
	assign o_hbp      = fields[3];
	assign o_height   = fields[4];
	assign o_vfp      = fields[5];
	assign o_vs_len   = fields[6];
	assign o_vbp      = fields[7];
	assign o_csync_en = cfg[CFG_CSYNC_BIT];
	assign o_vs_line  = vs_line;

	// Power on bit 4, disk on bit 2, user on bit 0
	assign led_default = {3'b000, i_led_status[2], 1'b0, i_led_status[1], 1'b0,
		i_led_status[0]};

	assign o_led = (led_mask & led_state) | (~led_mask & led_default);  // Host override per bit

endmodule

//--- logic/video_timing_calc.sv
`timescale 1ns/1ps

module video_timing_calc (
	input  logic                          i_clk_sys,
	input  logic                          i_resetd,
	input  hps_video_pkg::timing_field_t  i_width,
	input  hps_video_pkg::timing_field_t  i_hfp,
	input  hps_video_pkg::timing_field_t  i_hs_len,
	input  hps_video_pkg::timing_field_t  i_hbp,
	input  hps_video_pkg::timing_field_t  i_height,
	input  hps_video_pkg::timing_field_t  i_vfp,
	input  hps_video_pkg::timing_field_t  i_vs_len,
	input  hps_video_pkg::timing_field_t  i_vbp,
	output hps_video_pkg::timing_sum_t    o_hdisp,
	output hps_video_pkg::timing_sum_t    o_hsstart,
	output hps_video_pkg::timing_sum_t    o_hsend,
	output hps_video_pkg::timing_sum_t    o_htotal,
	output hps_video_pkg::timing_sum_t    o_vdisp,
	output hps_video_pkg::timing_sum_t    o_vsstart,
	output hps_video_pkg::timing_sum_t    o_vsend,
	output hps_video_pkg::timing_sum_t    o_vtotal
);
	import hps_video_pkg::*;

	timing_sum_t hsstart_c, hsend_c, htotal_c;
	timing_sum_t vsstart_c, vsend_c, vtotal_c;

	// Running sums where each stage builds on the last
	assign hsstart_c = timing_sum_t'(i_width) + timing_sum_t'(i_hfp);
	assign hsend_c   = hsstart_c + timing_sum_t'(i_hs_len);
	assign htotal_c  = hsend_c + timing_sum_t'(i_hbp);

	assign vsstart_c = timing_sum_t'(i_height) + timing_sum_t'(i_vfp);
	assign vsend_c   = vsstart_c + timing_sum_t'(i_vs_len);
	assign vtotal_c  = vsend_c + timing_sum_t'(i_vbp);

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			o_hdisp   <= timing_sum_t'(DEF_WIDTH);
			o_hsstart <= timing_sum_t'(DEF_WIDTH) + timing_sum_t'(DEF_HFP);
			o_hsend   <= timing_sum_t'(DEF_WIDTH) + timing_sum_t'(DEF_HFP) + timing_sum_t'(DEF_HS);
			o_htotal  <= timing_sum_t'(DEF_WIDTH) + timing_sum_t'(DEF_HFP) + timing_sum_t'(DEF_HS)
				+ timing_sum_t'(DEF_HBP);
			o_vdisp   <= timing_sum_t'(DEF_HEIGHT);
			o_vsstart <= timing_sum_t'(DEF_HEIGHT) + timing_sum_t'(DEF_VFP);
			o_vsend   <= timing_sum_t'(DEF_HEIGHT) + timing_sum_t'(DEF_VFP) + timing_sum_t'(DEF_VS);
			o_vtotal  <= timing_sum_t'(DEF_HEIGHT) + timing_sum_t'(DEF_VFP) + timing_sum_t'(DEF_VS)
				+ timing_sum_t'(DEF_VBP);
		end else begin
			o_hdisp   <= timing_sum_t'(i_width);
			o_hsstart <= hsstart_c;
			o_hsend   <= hsend_c;
			o_htotal  <= htotal_c;
			o_vdisp   <= timing_sum_t'(i_height);
			o_vsstart <= vsstart_c;
			o_vsend   <= vsend_c;
			o_vtotal  <= vtotal_c;
		end
	end

endmodule

//--- video_sync/sync_polarity_fix.sv
`timescale 1ns/1ps

module sync_polarity_fix (
	input  logic i_clk_sys,
	input  logic i_resetd,
	input  logic i_sync,
	output logic o_sync
);
	import hps_video_pkg::*;

	logic      sync_m;    // Synchroniser stages
	logic      sync_s;
	sync_cnt_t cnt;       // Cycles since last edge
	sync_cnt_t high_len;
	sync_cnt_t low_len;
	logic      invert;

	// Active part of the pulse is the shorter one
	assign o_sync = i_sync ^ invert;

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			sync_m   <= 1'b0;
			sync_s   <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			invert   <= 1'b0;
		end else begin
			sync_m <= i_sync;
			sync_s <= sync_m;
			if (sync_s != sync_m) begin
				cnt <= '0;
				if (sync_m) begin
					low_len <= cnt;   // Rising edge ends a low period
				end else begin
					high_len <= cnt;
				end
			end else if (!(&cnt)) begin
				cnt <= cnt + 1'b1;  // Saturates on a stuck input
			end
			invert <= high_len > low_len;
		end
	end

endmodule

//--- video_sync/csync_gen.sv
`timescale 1ns/1ps

module csync_gen (
	input  logic i_clk_sys,
	input  logic i_resetd,
	input  logic i_hsync,
	input  logic i_vsync,
	input  logic i_csync_en,
	output logic o_sync
);
	import hps_video_pkg::*;

	logic      hs_d;      // Horizontal sync one cycle late
	sync_cnt_t h_cnt;
	sync_cnt_t line_len;  // Blank part of the line
	sync_cnt_t hs_len;    // Sync pulse width
	logic      csync_hs;
	logic      csync_vs;

	assign o_sync = i_csync_en ? (csync_hs ^ csync_vs) : hs_d;

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			hs_d     <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
			csync_hs <= 1'b0;
			csync_vs <= 1'b0;
		end else begin
			hs_d  <= i_hsync;
			h_cnt <= h_cnt + 1'b1;

			// Line and pulse lengths
			if (hs_d ^ i_hsync) begin
				h_cnt <= '0;
				if (i_hsync) begin
					line_len <= h_cnt - hs_len;
					csync_hs <= 1'b0;
				end else begin
					hs_len <= h_cnt;
				end
			end

			if (!i_vsync) begin
				csync_hs <= i_hsync;
			end else if (h_cnt == line_len) begin
				csync_hs <= 1'b1;  // Serration pulse one width before the next line
			end

			csync_vs <= i_vsync;
		end
	end

endmodule

//--- video_sync/line_sync_marker.sv
`timescale 1ns/1ps

module line_sync_marker (
	input  logic                          i_clk_sys,
	input  logic                          i_resetd,
	input  logic                          i_hsync,
	input  logic                          i_de,
	input  hps_video_pkg::timing_field_t  i_vs_line,
	output logic                          o_video_sync
);
	import hps_video_pkg::*;

	logic          hs_d;
	logic          hs_rise;
	timing_field_t line_cnt;
	timing_field_t sync_line;  // Line to flag in the next frame
	logic [1:0]    blank_cnt;  // Line edges since display enable dropped

	assign hs_rise = !hs_d && i_hsync;

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			hs_d         <= 1'b0;
			line_cnt     <= '0;
			sync_line    <= '0;
			blank_cnt    <= '0;
			o_video_sync <= 1'b0;
		end else begin
			hs_d <= i_hsync;
			if (hs_rise) begin
				o_video_sync <= sync_line == line_cnt;
				line_cnt     <= line_cnt + 1'b1;
				if (!blank_cnt[1]) begin
					blank_cnt <= blank_cnt + 1'b1;
					// Second edge of blanking starts a new frame
					if (blank_cnt[0]) begin
						sync_line <= line_cnt - i_vs_line;
						line_cnt  <= '0;
					end
				end
			end
			if (i_de) begin
				blank_cnt <= '0;
			end
		end
	end

endmodule

//--- logic/hps_video_top.sv
`timescale 1ns/1ps

module hps_video_top (
	input  logic                        i_clk_sys,
	input  logic                        i_resetd,
	input  logic                        i_uio_sel,
	input  logic                        i_io_strobe,
	input  hps_video_pkg::io_word_t     i_io_din,
	input  logic                        i_hs_raw,
	input  logic                        i_vs_raw,
	input  logic                        i_de,
	input  logic [2:0]                  i_led_status,
	output logic                        o_hs,
	output logic                        o_vs,
	output logic                        o_sync_h,
	output logic                        o_video_sync,
	output hps_video_pkg::led_bank_t    o_led,
	output hps_video_pkg::timing_sum_t  o_hdisp,
	output hps_video_pkg::timing_sum_t  o_hsstart,
	output hps_video_pkg::timing_sum_t  o_hsend,
	output hps_video_pkg::timing_sum_t  o_htotal,
	output hps_video_pkg::timing_sum_t  o_vdisp,
	output hps_video_pkg::timing_sum_t  o_vsstart,
	output hps_video_pkg::timing_sum_t  o_vsend,
	output hps_video_pkg::timing_sum_t  o_vtotal
);
	import hps_video_pkg::*;

	timing_field_t width, hfp, hs_len, hbp;
	timing_field_t height, vfp, vs_len, vbp;
	timing_field_t vs_line;
	logic          csync_en;

	//////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////

	uio_cmd_decoder u_decoder (
		.i_clk_sys    (i_clk_sys),
		.i_resetd     (i_resetd),
		.i_uio_sel    (i_uio_sel),
		.i_io_strobe  (i_io_strobe),
		.i_io_din     (i_io_din),
		.i_led_status (i_led_status),
		.o_width      (width),
		.o_hfp        (hfp),
		.o_hs_len     (hs_len),
		.o_hbp        (hbp),
		.o_height     (height),
		.o_vfp        (vfp),
		.o_vs_len     (vs_len),
		.o_vbp        (vbp),
		.o_csync_en   (csync_en),
		.o_vs_line    (vs_line),
		.o_led        (o_led)
	);

	video_timing_calc u_timing (
		.i_clk_sys (i_clk_sys),
		.i_resetd  (i_resetd),
		.i_width   (width),
		.i_hfp     (hfp),
		.i_hs_len  (hs_len),
		.i_hbp     (hbp),
		.i_height  (height),
		.i_vfp     (vfp),
		.i_vs_len  (vs_len),
		.i_vbp     (vbp),
		.o_hdisp   (o_hdisp),
		.o_hsstart (o_hsstart),
		.o_hsend   (o_hsend),
		.o_htotal  (o_htotal),
		.o_vdisp   (o_vdisp),
		.o_vsstart (o_vsstart),
		.o_vsend   (o_vsend),
		.o_vtotal  (o_vtotal)
	);

	//////////////////////////////////////////////////
	// Video sync path
	//////////////////////////////////////////////////

	sync_polarity_fix u_sync_h (
		.i_clk_sys (i_clk_sys),
		.i_resetd  (i_resetd),
		.i_sync    (i_hs_raw),
		.o_sync    (o_hs)
	);

	sync_polarity_fix u_sync_v (
		.i_clk_sys (i_clk_sys),
		.i_resetd  (i_resetd),
		.i_sync    (i_vs_raw),
		.o_sync    (o_vs)
	);

	csync_gen u_csync (
		.i_clk_sys  (i_clk_sys),
		.i_resetd   (i_resetd),
		.i_hsync    (o_hs),
		.i_vsync    (o_vs),
		.i_csync_en (csync_en),
		.o_sync     (o_sync_h)
	);

	line_sync_marker u_marker (
		.i_clk_sys    (i_clk_sys),
		.i_resetd     (i_resetd),
		.i_hsync      (o_hs),
		.i_de         (i_de),
		.i_vs_line    (vs_line),
		.o_video_sync (o_video_sync)
	);

endmodule

//--- verification/hps_video_sva.sv
`timescale 1ns/1ps

module hps_video_sva (
	input logic                        i_clk_sys,
	input logic                        i_resetd,
	input hps_video_pkg::timing_sum_t  i_hsstart,
	input hps_video_pkg::timing_sum_t  i_hsend,
	input hps_video_pkg::timing_sum_t  i_htotal,
	input hps_video_pkg::timing_sum_t  i_vsstart,
	input hps_video_pkg::timing_sum_t  i_vsend,
	input hps_video_pkg::timing_sum_t  i_vtotal,
	input logic                        i_video_sync
);

	// Horizontal totals stay ordered
	a_h_order: assert property (@(posedge i_clk_sys) disable iff (i_resetd)
		i_hsstart <= i_hsend && i_hsend <= i_htotal)
		else $error("Horizontal sync start, sync end and total out of order");

	a_v_order: assert property (@(posedge i_clk_sys) disable iff (i_resetd)
		i_vsstart <= i_vsend && i_vsend <= i_vtotal)
		else $error("Vertical sync start, sync end and total out of order");

	// Marker cleared by the first reset edge
	a_mark_reset: assert property (@(posedge i_clk_sys) i_resetd |=> !i_video_sync)
		else $error("Line sync marker high during reset");

endmodule

bind hps_video_top hps_video_sva u_sva (
	.i_clk_sys    (i_clk_sys),
	.i_resetd     (i_resetd),
	.i_hsstart    (o_hsstart),
	.i_hsend      (o_hsend),
	.i_htotal     (o_htotal),
	.i_vsstart    (o_vsstart),
	.i_vsend      (o_vsend),
	.i_vtotal     (o_vtotal),
	.i_video_sync (o_video_sync)
);

//--- verification/tb_hps_video.sv
`timescale 1ns/1ps

module tb_hps_video;
	import hps_video_pkg::*;

	localparam int SYNC_LEN     = 4;   // Raw sync low cycles per line
	localparam int LINE_LEN     = 16;
	localparam int ACTIVE_LINES = 6;
	localparam int FRAME_LINES  = 10;
	localparam int MEAS_FRAMES  = 4;

	logic        clk_sys;
	logic        resetd;
	logic        uio_sel;
	logic        io_strobe;
	io_word_t    io_din;
	logic        hs_raw;
	logic        vs_raw;
	logic        de;
	logic [2:0]  led_status;
	logic        hs;
	logic        vs;
	logic        sync_h;
	logic        video_sync;
	led_bank_t   led;
	timing_sum_t hdisp, hsstart, hsend, htotal;
	timing_sum_t vdisp, vsstart, vsend, vtotal;

	int          errors;
	logic [31:0] seed;
	string       test_name;
	logic        chk_pol;     // Per-cycle checks inside drive_line
	logic        chk_csync;
	logic        prev_valid;
	logic        prev_hs;     // Expected o_hs of the previous cycle
	logic        pol_ok;      // Whole line had o_hs high only in the sync part
	logic        line_mark;   // o_video_sync in the middle of the last line

	hps_video_top DUT (
		.i_clk_sys    (clk_sys),
		.i_resetd     (resetd),
		.i_uio_sel    (uio_sel),
		.i_io_strobe  (io_strobe),
		.i_io_din     (io_din),
		.i_hs_raw     (hs_raw),
		.i_vs_raw     (vs_raw),
		.i_de         (de),
		.i_led_status (led_status),
		.o_hs         (hs),
		.o_vs         (vs),
		.o_sync_h     (sync_h),
		.o_video_sync (video_sync),
		.o_led        (led),
		.o_hdisp      (hdisp),
		.o_hsstart    (hsstart),
		.o_hsend      (hsend),
		.o_htotal     (htotal),
		.o_vdisp      (vdisp),
		.o_vsstart    (vsstart),
		.o_vsend      (vsend),
		.o_vtotal     (vtotal)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic led_bank_t led_pattern(input logic [2:0] status);
		led_bank_t p;
		p    = '0;
		p[4] = status[2];  // Power
		p[2] = status[1];  // Disk
		p[0] = status[0];  // User
		return p;
	endfunction

	task automatic check_value(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			errors++;
			$display("Fail %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic strobe_word(input io_word_t w);
		io_strobe = 1'b1;
		io_din    = w;
		tick();
		io_strobe = 1'b0;
		tick();
	endtask

	task automatic open_cmd(input cmd_code_t cmd, input logic [7:0] high);
		uio_sel = 1'b1;
		strobe_word({high, cmd});
	endtask

	task automatic close_cmd();
		uio_sel = 1'b0;
		tick();
	endtask

	// One video line with raw horizontal sync active low at the start
	task automatic drive_line(input logic active);
		pol_ok = 1'b1;
		for (int c = 0; c < LINE_LEN; c++) begin
			hs_raw = c >= SYNC_LEN;
			de     = active && c >= SYNC_LEN + 2 && c < LINE_LEN - 2;
			#1;
			if (hs !== (c < SYNC_LEN)) begin
				pol_ok = 1'b0;
			end
			if (chk_pol) begin
				check_value("o_hs", c < SYNC_LEN, hs);
			end
			if (chk_csync && prev_valid) begin
				check_value("o_sync_h", prev_hs, sync_h);  // One cycle behind o_hs
			end
			if (c == LINE_LEN / 2) begin
				line_mark = video_sync;
			end
			prev_hs    = c < SYNC_LEN;
			prev_valid = 1'b1;
			tick();
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset_values();
		test_name  = "reset_values";
		led_status = 3'b101;
		#1;
		check_value("o_htotal", 2204, htotal);
		check_value("o_vtotal", 1125, vtotal);
		check_value("o_hsstart", 2008, hsstart);
		check_value("o_led", led_pattern(3'b101), led);
		tick();
	endtask

	task automatic test_timing();
		timing_field_t f [8];
		int            h_ss;
		int            v_ss;
		test_name = "video_timing";
		open_cmd(CMD_VIDEO_TIMING, 8'h00);
		for (int i = 0; i < TIMING_WORDS; i++) begin
			seed = xorshift32(seed);
			f[i] = {2'b00, seed[9:0]};
			strobe_word({4'h0, f[i]});
		end
		h_ss = int'(f[0]) + int'(f[1]);
		v_ss = int'(f[4]) + int'(f[5]);
		for (int pass = 0; pass < 2; pass++) begin
			check_value("o_hdisp", f[0], hdisp);
			check_value("o_hsstart", h_ss, hsstart);
			check_value("o_hsend", h_ss + f[2], hsend);
			check_value("o_htotal", h_ss + f[2] + f[3], htotal);
			check_value("o_vdisp", f[4], vdisp);
			check_value("o_vsstart", v_ss, vsstart);
			check_value("o_vsend", v_ss + f[6], vsend);
			check_value("o_vtotal", v_ss + f[6] + f[7], vtotal);
			if (pass == 0) begin
				seed = xorshift32(seed);
				strobe_word(seed[15:0]);  // Ninth word is ignored
			end
		end
		close_cmd();
	endtask

	task automatic test_led();
		io_word_t  w;
		led_bank_t pat;
		led_bank_t exp;
		test_name = "led_override";
		for (int t = 0; t < 4; t++) begin
			seed = xorshift32(seed);
			w    = seed[15:0];
			open_cmd(CMD_LED, 8'h00);
			strobe_word(w);
			close_cmd();
			// Fresh transaction takes its first word as a command again
			open_cmd(CMD_LED, seed[23:16]);
			for (int s = 0; s < 8; s++) begin
				led_status = s[2:0];
				#1;
				pat = led_pattern(s[2:0]);
				for (int b = 0; b < 8; b++) begin
					exp[b] = w[8 + b] ? w[b] : pat[b];
				end
				check_value("o_led", exp, led);
				tick();
			end
			close_cmd();
		end
	endtask

	task automatic test_polarity();
		int n;
		test_name = "sync_polarity";
		n         = 0;
		drive_line(1'b0);
		drive_line(1'b0);
		while (!pol_ok && n < 6) begin
			drive_line(1'b0);
			n++;
		end
		assert (pol_ok) else begin
			errors++;
			$display("Timeout: horizontal sync polarity never settled");
		end
		chk_pol = 1'b1;
		drive_line(1'b0);
		drive_line(1'b0);
		chk_pol = 1'b0;
	endtask

	task automatic test_csync();
		test_name = "csync_off";
		seed      = xorshift32(seed);
		open_cmd(CMD_CFG, 8'h00);
		strobe_word(seed[15:0] & ~16'h0008);
		close_cmd();
		prev_valid = 1'b0;
		chk_csync  = 1'b1;
		drive_line(1'b0);
		drive_line(1'b0);
		chk_csync = 1'b0;
		test_name = "csync_on";  // Vertical sync stays inactive
		open_cmd(CMD_CFG, 8'h00);
		strobe_word(seed[31:16] | 16'h0008);
		close_cmd();
		check_value("o_vs", 0, vs);
		prev_valid = 1'b0;
		chk_csync  = 1'b1;
		drive_line(1'b0);
		drive_line(1'b0);
		chk_csync = 1'b0;
	endtask

	task automatic test_line_marker();
		int   off;
		int   pos;
		int   n;
		int   last_start;
		int   starts;
		int   marked;
		logic prev_mark;
		test_name = "line_marker";
		seed      = xorshift32(seed);
		off       = seed % FRAME_LINES;
		open_cmd(CMD_VS_LINE, 8'h00);
		strobe_word({seed[31:28], 12'(off)});
		close_cmd();
		pos = 0;
		for (int l = 0; l < 2 * FRAME_LINES; l++) begin
			drive_line(pos < ACTIVE_LINES);
			pos = (pos + 1) % FRAME_LINES;
		end
		n         = 0;
		line_mark = 1'b0;
		while (!line_mark && n < 2 * FRAME_LINES) begin
			drive_line(pos < ACTIVE_LINES);
			pos = (pos + 1) % FRAME_LINES;
			n++;
		end
		assert (line_mark) else begin
			errors++;
			$display("Timeout: no sync line marker seen within two frames");
		end
		last_start = 0;
		starts     = 0;
		marked     = 0;
		prev_mark  = 1'b1;
		for (int l = 1; l <= MEAS_FRAMES * FRAME_LINES; l++) begin
			drive_line(pos < ACTIVE_LINES);
			pos = (pos + 1) % FRAME_LINES;
			if (line_mark) begin
				marked++;
				if (!prev_mark) begin
					check_value("marker spacing", FRAME_LINES, l - last_start);
					last_start = l;
					starts++;
				end
			end
			prev_mark = line_mark;
		end
		check_value("marker count", MEAS_FRAMES, starts);
		check_value("marked lines", MEAS_FRAMES, marked);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		errors     = 0;
		seed       = 32'd69;
		test_name  = "init";
		chk_pol    = 1'b0;
		chk_csync  = 1'b0;
		prev_valid = 1'b0;
		prev_hs    = 1'b0;
		pol_ok     = 1'b0;
		line_mark  = 1'b0;
		resetd     = 1'b1;
		uio_sel    = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		hs_raw     = 1'b0;
		vs_raw     = 1'b0;
		de         = 1'b0;
		led_status = 3'b000;
		repeat (4) @(posedge clk_sys);
		#2;
		resetd = 1'b0;
		tick();

		test_reset_values();
		test_timing();
		test_led();
		test_polarity();
		test_csync();
		test_line_marker();

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- hps_video.f
common/hps_video_pkg.sv
logic/uio_cmd_decoder.sv
logic/video_timing_calc.sv
video_sync/sync_polarity_fix.sv
video_sync/csync_gen.sv
video_sync/line_sync_marker.sv
logic/hps_video_top.sv
verification/hps_video_sva.sv
verification/tb_hps_video.sv
